//--- hdl/bridgePkg.sv
package bridgePkg;

	////////////////////////////////////////
	// AHB transfer and response codes
	////////////////////////////////////////

	typedef enum logic [1:0]
	{
		idle   = 2'b00,
		busy   = 2'b01,
		nonSeq = 2'b10,
		seq    = 2'b11
	} transType;

	typedef enum logic [1:0]
	{
		okay  = 2'b00,
		error = 2'b01,
		retry = 2'b10,
		split = 2'b11
	} respType;

	////////////////////////////////////////
	// APB controller states
	////////////////////////////////////////

	typedef enum logic [2:0]
	{
		stIdle     = 3'b000,
		stWwait    = 3'b001,
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWriteP   = 3'b100,
		stREnable  = 3'b101,
		stWEnable  = 3'b110,
		stWEnableP = 3'b111
	} apbState;

	////////////////////////////////////////
	// address map
	////////////////////////////////////////

	localparam logic [31:0] slave0Base = 32'h8000_0000;
	localparam logic [31:0] slave1Base = 32'h8400_0000;
	localparam logic [31:0] slave2Base = 32'h8800_0000;
	localparam logic [31:0] regionSize = 32'h0400_0000;
	localparam int selWidth = 3; // one select per peripheral.

endpackage

//--- hdl/ahbSlaveInterface.sv
`timescale 1ns/1ps

module ahbSlaveInterface
	import bridgePkg::*;
(
	input  logic                Hclk,
	input  logic                Hresetn,
	input  transType            Htrans,
	input  logic                Hwrite,
	input  logic                Hreadyin,
	input  logic [31:0]         Haddr,
	input  logic [31:0]         Hwdata,
	output logic                valid,
	output logic [31:0]         Haddr1,
	output logic [31:0]         Haddr2,
	output logic [31:0]         Hwdata1,
	output logic [31:0]         Hwdata2,
	output logic                Hwritereg,
	output logic [selWidth-1:0] tempselx
);

	logic inRange0;
	logic inRange1;
	logic inRange2;
	logic activeTrans;

	////////////////////////////////////////
	// address and data pipeline
	////////////////////////////////////////

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Hwritereg <= 1'b0;
		end
		else
		begin
			Hwritereg <= Hwrite; // direction of the previous address phase.
		end
	end

	always_ff @(posedge Hclk)
	begin
		Haddr1  <= Haddr;
		Haddr2  <= Haddr1; // second stage feeds pipelined writes.
		Hwdata1 <= Hwdata;
		Hwdata2 <= Hwdata1;
	end

	////////////////////////////////////////
	// region decode
	////////////////////////////////////////

	always_comb
	begin
		inRange0 = (Haddr >= slave0Base) && (Haddr < slave0Base + regionSize);
		inRange1 = (Haddr >= slave1Base) && (Haddr < slave1Base + regionSize);
		inRange2 = (Haddr >= slave2Base) && (Haddr < slave2Base + regionSize);
	end

	always_comb
	begin
		tempselx = '0;
		if (inRange0)
		begin
			tempselx = 3'b001;
		end
		else if (inRange1)
		begin
			tempselx = 3'b010;
		end
		else if (inRange2)
		begin
			tempselx = 3'b100;
		end
	end

	// busy and idle cycles carry no transfer.
	assign activeTrans = (Htrans == nonSeq) || (Htrans == seq);

	assign valid = Hreadyin && activeTrans && (inRange0 || inRange1 || inRange2);

endmodule

//--- hdl/apbController.sv
`timescale 1ns/1ps

module apbController
	import bridgePkg::*;
(
	input  logic                Hclk,
	input  logic                Hresetn,
	input  logic                valid,
	input  logic [31:0]         Haddr,
	input  logic [31:0]         Haddr1,
	input  logic [31:0]         Haddr2,
	input  logic [31:0]         Hwdata,
	input  logic [31:0]         Hwdata1,
	input  logic [31:0]         Hwdata2,
	input  logic                Hwrite,
	input  logic                Hwritereg,
	input  logic [selWidth-1:0] tempselx,
	output logic                Pwrite,
	output logic                Penable,
	output logic [selWidth-1:0] Pselx,
	output logic [31:0]         Paddr,
	output logic [31:0]         Pwdata,
	output logic                Hreadyout
);

	apbState presentState;
	apbState nextState;

	logic                pwriteNext;
	logic                penableNext;
	logic [selWidth-1:0] pselNext;
	logic [31:0]         paddrNext;
	logic [31:0]         pwdataNext;
	logic                hreadyoutNext;

	////////////////////////////////////////
	// state register
	////////////////////////////////////////

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			presentState <= stIdle;
		end
		else
		begin
			presentState <= nextState;
		end
	end

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb
	begin
		nextState = stIdle;
		case (presentState)
			stIdle, stREnable, stWEnable:
			begin
				if (!valid)
				begin
					nextState = stIdle;
				end
				else if (Hwrite)
				begin
					nextState = stWwait;
				end
				else
				begin
					nextState = stRead;
				end
			end
			stWwait:
			begin
				nextState = valid ? stWriteP : stWrite; // a second address phase pipelines.
			end
			stRead:
			begin
				nextState = stREnable;
			end
			stWrite:
			begin
				nextState = valid ? stWEnableP : stWEnable;
			end
			stWriteP:
			begin
				nextState = stWEnableP;
			end
			stWEnableP:
			begin
				if (!valid && Hwritereg)
				begin
					nextState = stWrite;
				end
				else if (valid && Hwritereg)
				begin
					nextState = stWriteP;
				end
				else
				begin
					nextState = stRead;
				end
			end
			default:
			begin
				nextState = stIdle;
			end
		endcase
	end

	////////////////////////////////////////
	// output decode
	////////////////////////////////////////

	always_comb
	begin
		pwriteNext    = Pwrite;
		penableNext   = 1'b0;
		pselNext      = Pselx; // select holds through the enable phase.
		paddrNext     = Paddr;
		pwdataNext    = Pwdata;
		hreadyoutNext = Hreadyout;
		case (presentState)
			stIdle, stREnable, stWEnable:
			begin
				if (valid && !Hwrite)
				begin
					paddrNext     = Haddr; // reads start on the live address.
					pwriteNext    = 1'b0;
					pselNext      = tempselx;
					hreadyoutNext = 1'b0;
				end
				else
				begin
					pselNext      = '0;
					hreadyoutNext = 1'b1;
				end
			end
			stWwait:
			begin
				paddrNext     = Haddr1;
				pwriteNext    = 1'b1;
				pselNext      = tempselx;
				pwdataNext    = Hwdata; // data phase of the first write.
				hreadyoutNext = 1'b0;
			end
			stRead, stWrite, stWriteP:
			begin
				penableNext   = 1'b1;
				hreadyoutNext = 1'b1;
			end
			stWEnableP:
			begin
				paddrNext     = Haddr2;
				pwriteNext    = Hwritereg;
				pselNext      = tempselx;
				pwdataNext    = Hwdata;
				hreadyoutNext = 1'b0;
			end
			default:
			begin
				pselNext      = '0;
				hreadyoutNext = 1'b1;
			end
		endcase
	end

	////////////////////////////////////////
	// registered APB outputs
	////////////////////////////////////////

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Pwrite    <= 1'b0;
			Penable   <= 1'b0;
			Pselx     <= '0;
			Paddr     <= '0;
			Pwdata    <= '0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			Pwrite    <= pwriteNext;
			Penable   <= penableNext;
			Pselx     <= pselNext;
			Paddr     <= paddrNext;
			Pwdata    <= pwdataNext;
			Hreadyout <= hreadyoutNext;
		end
	end

endmodule

//--- hdl/ahbApbBridge.sv
`timescale 1ns/1ps

module ahbApbBridge
	import bridgePkg::*;
(
	input  logic                Hclk,
	input  logic                Hresetn,
	input  transType            Htrans,
	input  logic                Hwrite,
	input  logic                Hreadyin,
	input  logic [31:0]         Haddr,
	input  logic [31:0]         Hwdata,
	output logic [31:0]         Hrdata,
	output respType             Hresp,
	output logic                Hreadyout,
	output logic [31:0]         Paddr,
	output logic [31:0]         Pwdata,
	output logic                Pwrite,
	output logic [selWidth-1:0] Pselx,
	output logic                Penable,
	input  logic [31:0]         Prdata
);

	logic                valid;
	logic [31:0]         haddr1;
	logic [31:0]         haddr2;
	logic [31:0]         hwdata1;
	logic [31:0]         hwdata2;
	logic                hwritereg;
	logic [selWidth-1:0] tempselx;

	ahbSlaveInterface ahbSlave
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Htrans    (Htrans),
		.Hwrite    (Hwrite),
		.Hreadyin  (Hreadyin),
		.Haddr     (Haddr),
		.Hwdata    (Hwdata),
		.valid     (valid),
		.Haddr1    (haddr1),
		.Haddr2    (haddr2),
		.Hwdata1   (hwdata1),
		.Hwdata2   (hwdata2),
		.Hwritereg (hwritereg),
		.tempselx  (tempselx)
	);

	apbController apbCtrl
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.valid     (valid),
		.Haddr     (Haddr),
		.Haddr1    (haddr1),
		.Haddr2    (haddr2),
		.Hwdata    (Hwdata),
		.Hwdata1   (hwdata1),
		.Hwdata2   (hwdata2),
		.Hwrite    (Hwrite),
		.Hwritereg (hwritereg),
		.tempselx  (tempselx),
		.Pwrite    (Pwrite),
		.Penable   (Penable),
		.Pselx     (Pselx),
		.Paddr     (Paddr),
		.Pwdata    (Pwdata),
		.Hreadyout (Hreadyout)
	);

	assign Hrdata = Prdata; // read data is not registered.
	assign Hresp  = okay;

endmodule

//--- test/apbMemoryModel.sv
`timescale 1ns/1ps

module apbMemoryModel
	import bridgePkg::*;
(
	input  logic                Hclk,
	input  logic [selWidth-1:0] Pselx,
	input  logic                Penable,
	input  logic                Pwrite,
	input  logic [31:0]         Paddr,
	input  logic [31:0]         Pwdata,
	output logic [31:0]         Prdata
);

	logic [31:0] mem [3*16]; // bank * 16 + word.
	logic [5:0]  index;
	logic [1:0]  bank;

	initial
	begin
		for (int i = 0; i < 3*16; i++)
		begin
			mem[i] = 32'hC0DE_0000 ^ (i * 32'h0101_0101);
		end
	end

	always_comb
	begin
		bank = 2'd0;
		case (Pselx)
			3'b010: bank = 2'd1;
			3'b100: bank = 2'd2;
			default: bank = 2'd0;
		endcase
		index = {bank, Paddr[5:2]};
	end

	always @(posedge Hclk)
	begin
		if ((|Pselx) && Penable && Pwrite)
		begin
			mem[index] <= Pwdata; // write lands at the end of the enable phase.
		end
	end

	assign Prdata = ((|Pselx) && !Pwrite) ? mem[index] : '0;

endmodule

//--- test/apbController_assertions.sv
`timescale 1ns/1ps

module apbControllerAssertions
	import bridgePkg::*;
(
	input logic                Hclk,
	input logic                Hresetn,
	input logic                valid,
	input logic                Hwrite,
	input logic                Hwritereg,
	input apbState             presentState,
	input logic [selWidth-1:0] Pselx,
	input logic                Penable
);

	int assertFails = 0;
	logic restState;

	assign restState = (presentState == stIdle) || (presentState == stREnable) ||
		(presentState == stWEnable);

	////////////////////////////////////////
	// state transitions
	////////////////////////////////////////

	startWrite: assert property (@(posedge Hclk) disable iff (!Hresetn)
		restState && valid && Hwrite |=> presentState == stWwait)
		else begin $error("write not started from rest state"); assertFails++; end

	startRead: assert property (@(posedge Hclk) disable iff (!Hresetn)
		restState && valid && !Hwrite |=> presentState == stRead)
		else begin $error("read not started from rest state"); assertFails++; end

	waitStep: assert property (@(posedge Hclk) disable iff (!Hresetn)
		presentState == stWwait |=> presentState == ($past(valid) ? stWriteP : stWrite))
		else begin $error("bad exit from write wait"); assertFails++; end

	readStep: assert property (@(posedge Hclk) disable iff (!Hresetn)
		presentState == stRead |=> presentState == stREnable)
		else begin $error("read setup not followed by enable"); assertFails++; end

	pipeStep: assert property (@(posedge Hclk) disable iff (!Hresetn)
		presentState == stWEnableP && valid && Hwritereg |=> presentState == stWriteP)
		else begin $error("pipelined write not continued"); assertFails++; end

	////////////////////////////////////////
	// APB protocol
	////////////////////////////////////////

	enableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> (Pselx != '0) && !$past(Penable) && ($past(Pselx) == Pselx))
		else begin $error("enable phase without matching setup"); assertFails++; end

	selOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(Pselx))
		else begin $error("more than one select active"); assertFails++; end

endmodule

bind apbController apbControllerAssertions ctrlChecks
(
	.Hclk         (Hclk),
	.Hresetn      (Hresetn),
	.valid        (valid),
	.Hwrite       (Hwrite),
	.Hwritereg    (Hwritereg),
	.presentState (presentState),
	.Pselx        (Pselx),
	.Penable      (Penable)
);

//--- test/bridgeTb.sv
`timescale 1ns/1ps

module bridgeTb
	import bridgePkg::*;
;

	logic Hclk;
	logic Hresetn;
	transType Htrans;
	logic Hwrite;
	logic Hreadyin;
	logic [31:0] Haddr;
	logic [31:0] Hwdata;
	logic [31:0] Hrdata;
	respType Hresp;
	logic Hreadyout;
	logic [31:0] Paddr;
	logic [31:0] Pwdata;
	logic Pwrite;
	logic [selWidth-1:0] Pselx;
	logic Penable;
	logic [31:0] Prdata;

	logic [31:0] seed = 32'h5058;
	int cycles = 0;
	logic [31:0] savedAddr [3];
	logic [31:0] savedData [3];

	ahbApbBridge DUT (.*);

	apbMemoryModel memModel (.Hclk(Hclk), .Pselx(Pselx), .Penable(Penable),
		.Pwrite(Pwrite), .Paddr(Paddr), .Pwdata(Pwdata), .Prdata(Prdata));

	initial
	begin
		Hclk = 1'b0;
		forever #5 Hclk = ~Hclk;
	end

	always @(posedge Hclk)
	begin
		cycles++;
		if (cycles >= 2000)
		begin
			$display("timeout: the bridge never finished its transfers");
			$display("SOME TESTS FAILED");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	always @(DUT.apbCtrl.ctrlChecks.assertFails)
	begin
		if (DUT.apbCtrl.ctrlChecks.assertFails != 0)
		begin
			$display("SOME TESTS FAILED");
			$fatal(1, "a controller assertion failed");
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	function automatic int memIndex(logic [31:0] addr);
		return ((addr - slave0Base) / regionSize) * 16 + addr[5:2]; // region then word.
	endfunction

	task automatic checkWord(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic checkResp(string name, respType got, respType exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns %s: got %s, expected %s", $time, name, got.name(), exp.name());
			$display("SOME TESTS FAILED");
			$fatal(1, "response mismatch");
		end
	endtask

	task automatic checkSel(string name, logic [selWidth-1:0] got, logic [selWidth-1:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "select mismatch");
		end
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	// ends one drive delay after the edge that completes the current phase.
	task automatic waitReady();
		do @(negedge Hclk); while (!Hreadyout);
		@(posedge Hclk);
		#1;
	endtask

	// ends one drive delay after the edge that closes the enable phase.
	task automatic drainApb();
		do @(negedge Hclk); while (Hreadyout);
		do @(negedge Hclk); while (!Hreadyout);
		@(posedge Hclk);
		#1;
	endtask

	////////////////////////////////////////
	// AHB master tasks
	////////////////////////////////////////

	task automatic ahbBurstWrite(logic [31:0] addr, int n, logic [31:0] words [4]);
		@(posedge Hclk);
		#1;
		Htrans = nonSeq;
		Hwrite = 1'b1;
		Haddr  = addr;
		for (int i = 1; i < n; i++)
		begin
			waitReady();
			Htrans = seq;
			Haddr  = addr + 4 * i;
			Hwdata = words[i-1]; // data of the previous beat.
		end
		waitReady();
		Htrans = idle;
		Hwdata = words[n-1];
		waitReady();
		drainApb();
	endtask

	task automatic ahbWrite(logic [31:0] addr, logic [31:0] data);
		logic [31:0] words [4];
		words = '{data, 32'h0, 32'h0, 32'h0};
		ahbBurstWrite(addr, 1, words);
	endtask

	task automatic ahbRead(logic [31:0] addr, output logic [31:0] data, output respType resp);
		@(posedge Hclk);
		#1;
		Htrans = nonSeq;
		Hwrite = 1'b0;
		Haddr  = addr;
		waitReady();
		Htrans = idle;
		do @(negedge Hclk); while (!Hreadyout);
		data = Hrdata;
		resp = Hresp;
	endtask

	task automatic readAndCheck(logic [31:0] addr, logic [31:0] exp);
		logic [31:0] data;
		respType resp;
		ahbRead(addr, data, resp);
		checkWord("Hrdata", data, exp);
		checkResp("Hresp", resp, okay);
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic resetTest();
		Hresetn = 1'b0;
		repeat (3) @(posedge Hclk);
		#1;
		Hresetn = 1'b1;
		checkSel("Pselx", Pselx, '0);
		checkBit("Penable", Penable, 1'b0);
		@(posedge Hclk);
		@(negedge Hclk);
		checkBit("Hreadyout", Hreadyout, 1'b1); // first clock after release.
	endtask

	task automatic singleWriteTest();
		logic [31:0] bases [3];
		bases = '{slave0Base, slave1Base, slave2Base};
		for (int r = 0; r < 3; r++)
		begin
			savedAddr[r] = bases[r] + ((xorshift32() & 32'hF) << 2);
			savedData[r] = xorshift32();
			ahbWrite(savedAddr[r], savedData[r]);
			checkWord("Paddr", Paddr, savedAddr[r]); // held after the enable phase.
			checkWord("Pwdata", Pwdata, savedData[r]);
			checkBit("Pwrite", Pwrite, 1'b1);
			checkWord("memModel.mem", memModel.mem[memIndex(savedAddr[r])], savedData[r]);
			readAndCheck(savedAddr[r], savedData[r]);
		end
	endtask

	task automatic burstWriteTest();
		logic [31:0] words [4];
		for (int i = 0; i < 4; i++)
		begin
			words[i] = xorshift32();
		end
		ahbBurstWrite(slave1Base + 32'h20, 4, words);
		for (int i = 0; i < 4; i++)
		begin
			readAndCheck(slave1Base + 32'h20 + 4 * i, words[i]);
		end
	endtask

	task automatic backToBackReadTest();
		for (int r = 2; r >= 0; r--)
		begin
			readAndCheck(savedAddr[r], savedData[r]);
		end
	endtask

	task automatic ignoredTransferTest();
		@(posedge Hclk);
		#1;
		Htrans = idle; // in range but idle.
		Hwrite = 1'b1;
		Haddr  = savedAddr[0];
		Hwdata = xorshift32();
		repeat (4)
		begin
			@(negedge Hclk);
			checkSel("Pselx", Pselx, '0);
		end
		@(posedge Hclk);
		#1;
		Htrans = nonSeq;
		Haddr  = 32'h4000_0000; // outside every region.
		repeat (4)
		begin
			@(negedge Hclk);
			checkSel("Pselx", Pselx, '0);
		end
		@(posedge Hclk);
		#1;
		Htrans = idle;
		readAndCheck(savedAddr[0], savedData[0]);
	endtask

	task automatic writeThenReadTest();
		savedData[2] = xorshift32();
		ahbWrite(savedAddr[2], savedData[2]);
		readAndCheck(savedAddr[2], savedData[2]);
	endtask

	initial
	begin
		Hresetn  = 1'b0;
		Htrans   = idle;
		Hwrite   = 1'b0;
		Hreadyin = 1'b1; // single slave, always ready for the next address.
		Haddr    = '0;
		Hwdata   = '0;
		resetTest();
		singleWriteTest();
		burstWriteTest();
		backToBackReadTest();
		ignoredTransferTest();
		writeThenReadTest();
		repeat (2) @(posedge Hclk);
		#1;
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- list.f
hdl/bridgePkg.sv
hdl/ahbSlaveInterface.sv
hdl/apbController.sv
hdl/ahbApbBridge.sv
test/apbMemoryModel.sv
test/apbController_assertions.sv
test/bridgeTb.sv
